/* files.f */
+incdir+verification
logic/lsu_bus_pkg.sv
logic/lsu_access_pkg.sv
logic/lsu_request_former.sv
logic/lsu_bus_ctrl.sv
logic/lsu_load_aligner.sv
logic/lsu_top.sv
verification/lsu_tb.sv

/* logic/lsu_access_pkg.sv */
/*
  access format definitions for the load-store unit
  size and extension encodings, byte enables and the read-word views
*/
package lsu_access_pkg;

  // bytes in one data word
  localparam int unsigned BYTES_PER_WORD = 4;

  //////////////////////////////
  // encodings from execute
  //////////////////////////////

  // access size, both byte codes behave the same
  typedef enum logic [1:0] {
    SIZE_WORD     = 2'b00,
    SIZE_HALF     = 2'b01,
    SIZE_BYTE     = 2'b10,
    SIZE_BYTE_ALT = 2'b11
  } size_e;

  // load extension mode
  // sign has two codes, ones fills the upper bits with 1
  typedef enum logic [1:0] {
    EXT_ZERO     = 2'b00,
    EXT_SIGN     = 2'b01,
    EXT_ONES     = 2'b10,
    EXT_SIGN_ALT = 2'b11
  } ext_e;

  //////////////////////////////
  // word layout
  //////////////////////////////

  typedef logic [BYTES_PER_WORD-1:0] be_t;
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_ofs_t;

  // all lanes enabled, shifted per offset
  localparam be_t BE_ALL = '1;

  // one read word seen as bytes or as halfwords
  typedef union packed {
    logic [BYTES_PER_WORD-1:0][7:0]    b;
    logic [BYTES_PER_WORD/2-1:0][15:0] h;
  } rword_u;

endpackage

/* logic/lsu_bus_ctrl.sv */
/*
  bus controller of the load-store unit
  issues requests, counts outstanding transfers and
  derives stage-ready and busy
*/
`timescale 1ns/100ps

module lsu_bus_ctrl
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  data_req_ex_i,
  input  logic  data_we_ex_i,
  // address phase, watched by the checks only
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_req_o,
  output logic  lsu_ready_ex_o,
  output logic  lsu_ready_wb_o,
  output logic  busy_o,
  output logic  ctrl_update_o,
  output logic  resp_valid_o
);

  cnt_t cnt_q;
  cnt_t cnt_d;
  // transfer taken by the bus this cycle
  logic accept;

  // no path from rvalid to the request
  assign data_req_o   = data_req_ex_i && (cnt_q < OUTSTANDING_MAX);
  assign accept       = data_req_o && data_gnt_i;
  assign resp_valid_o = data_rvalid_i;

  //////////////////////////////
  // outstanding counter
  //////////////////////////////

  // accept and rvalid together leave the count as is
  always_comb begin
    case ({accept, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);
      2'b01:   cnt_d = cnt_q - cnt_t'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////
  // stage ready
  //////////////////////////////

  // writeback frees up with the awaited response
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // execute and writeback advance in lock step once writeback holds something
  always_comb begin
    lsu_ready_ex_o = 1'b1;
    if (data_req_ex_i) begin
      case (cnt_q)
        cnt_t'(0): lsu_ready_ex_o = accept;
        cnt_t'(1): lsu_ready_ex_o = accept && data_rvalid_i;
        default:   lsu_ready_ex_o = data_rvalid_i;
      endcase
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o        = (cnt_q != '0) || data_req_o;

  // request gating keeps the counter within the bus depth
  a_cnt_bound : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= OUTSTANDING_MAX)
    else $error("outstanding count above limit");

  // every response must belong to an accepted transfer
  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0))
    else $error("rvalid with nothing outstanding");

  // address phase from the request former is defined while on the bus
  a_addr_phase_known : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown({addr_i, be_i, data_we_ex_i})
                   && (!data_we_ex_i || !$isunknown(wdata_i)))
    else $error("unknown address phase during request");

endmodule

/* logic/lsu_bus_pkg.sv */
/*
  data bus definitions for the load-store unit
  word types and outstanding-transaction limit of the req/gnt/rvalid bus
*/
package lsu_bus_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // byte address, one word wide
  localparam int unsigned ADDR_W = 32;
  // data word on both write and read channels
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  //////////////////////////////
  // outstanding transactions
  //////////////////////////////

  // counter of accepted but unanswered transfers
  localparam int unsigned CNT_W = 2;

  typedef logic [CNT_W-1:0] cnt_t;

  // at most two transfers in flight
  // the request is held off the bus once this is reached
  localparam cnt_t OUTSTANDING_MAX = cnt_t'(2);

endpackage

/* logic/lsu_load_aligner.sv */
/*
  load aligner of the load-store unit
  holds writeback control, buffers split loads, and
  selects, assembles and extends read data
*/
`timescale 1ns/100ps

module lsu_load_aligner
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ctrl_update_i,
  input  logic      resp_valid_i,
  input  data_t     data_rdata_i,
  input  size_e     data_type_ex_i,
  input  ext_e      data_sign_ext_ex_i,
  input  logic      data_we_ex_i,
  input  byte_ofs_t offset_i,
  input  logic      data_misaligned_ex_i,
  input  logic      data_misaligned_i,
  output data_t     data_rdata_ex_o
);

  // writeback copy of the access format
  size_e       data_type_q;
  ext_e        data_sign_ext_q;
  logic        data_we_q;
  byte_ofs_t   rdata_offset_q;
  // live response and buffered word
  rword_u      resp;
  rword_u      rdata_q;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  data_t       word_asm;
  data_t       rdata_ext;
  logic        raw_capture;

  // upper fill bit per extension mode
  function automatic logic fill_bit(ext_e mode, logic msb);
    case (mode)
      EXT_ZERO: return 1'b0;
      EXT_ONES: return 1'b1;
      default:  return msb;
    endcase
  endfunction

  //////////////////////////////
  // writeback control
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q     <= SIZE_WORD;
      data_sign_ext_q <= EXT_ZERO;
      data_we_q       <= 1'b0;
      rdata_offset_q  <= '0;
    end else if (ctrl_update_i) begin
      data_type_q     <= data_type_ex_i;
      data_sign_ext_q <= data_sign_ext_ex_i;
      data_we_q       <= data_we_ex_i;
      rdata_offset_q  <= offset_i;
    end
  end

  //////////////////////////////
  // alignment
  //////////////////////////////

  assign resp     = data_rdata_i;
  assign byte_sel = resp.b[rdata_offset_q];

  // offset 3 takes its low byte from the buffered first word
  always_comb begin
    case (rdata_offset_q)
      2'd0:    half_sel = resp.h[0];
      2'd1:    half_sel = {resp.b[2], resp.b[1]};
      2'd2:    half_sel = resp.h[1];
      default: half_sel = {resp.b[0], rdata_q.b[3]};
    endcase
  end

  // split word, upper bytes of the first word below low bytes of the second
  always_comb begin
    case (rdata_offset_q)
      2'd0:    word_asm = resp;
      2'd1:    word_asm = {resp.b[0], rdata_q.b[3:1]};
      2'd2:    word_asm = {resp.h[0], rdata_q.h[1]};
      default: word_asm = {resp.b[2:0], rdata_q.b[3]};
    endcase
  end

  always_comb begin
    case (data_type_q)
      SIZE_WORD: rdata_ext = word_asm;
      SIZE_HALF: rdata_ext = {{16{fill_bit(data_sign_ext_q, half_sel[15])}}, half_sel};
      default:   rdata_ext = {{24{fill_bit(data_sign_ext_q, byte_sel[7])}}, byte_sel};
    endcase
  end

  //////////////////////////////
  // result buffer
  //////////////////////////////

  // first part of a split load keeps the raw word
  // its response comes back while the second part is presented
  assign raw_capture = resp_valid_i && !data_we_q && data_misaligned_ex_i;

  always_ff @(posedge clk) begin
    if (resp_valid_i && !data_we_q) begin
      if (raw_capture) begin
        rdata_q <= resp;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  // live result with rvalid, held value after
  assign data_rdata_ex_o = resp_valid_i ? rdata_ext : data_t'(rdata_q);

  // second response of a split load is a read, so the raw word is not lost
  a_split_load_reads : assert property (@(posedge clk) disable iff (!rst_n)
    raw_capture |=> !(resp_valid_i && data_we_q) until (resp_valid_i && !data_we_q))
    else $error("write response while a split load is buffered");

endmodule

/* logic/lsu_request_former.sv */
/*
  request former of the load-store unit
  builds bus address, byte enables and rotated store data,
  and flags accesses that need a second bus transfer
*/
`timescale 1ns/100ps

module lsu_request_former
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic      data_req_ex_i,
  input  size_e     data_type_ex_i,
  input  data_t     data_wdata_ex_i,
  input  byte_ofs_t data_reg_offset_ex_i,
  input  data_t     operand_a_ex_i,
  input  data_t     operand_b_ex_i,
  input  logic      addr_useincr_ex_i,
  input  logic      data_misaligned_ex_i,
  output addr_t     addr_o,
  output byte_ofs_t offset_o,
  output be_t       be_o,
  output data_t     wdata_o,
  output logic      data_misaligned_o
);

  addr_t       addr_int;
  byte_ofs_t   ofs;
  // byte rotation for store data
  byte_ofs_t   wdata_ofs;
  logic [63:0] wdata_dbl;

  //////////////////////////////
  // address
  //////////////////////////////

  // base register alone or base plus offset operand
  assign addr_int = addr_useincr_ex_i ? addr_t'(operand_a_ex_i + operand_b_ex_i)
                                      : addr_t'(operand_a_ex_i);
  assign ofs      = addr_int[1:0];
  assign offset_o = ofs;

  // second part starts at the next word boundary
  assign addr_o = data_misaligned_ex_i ? {addr_int[31:2], 2'b00} : addr_int;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    case (data_type_ex_i)
      SIZE_WORD: begin
        if (!data_misaligned_ex_i) begin
          // offset up to the top lane
          be_o = be_t'(BE_ALL << ofs);
        end else begin
          // leftover low lanes in the next word
          be_o = ~be_t'(BE_ALL << ofs);
        end
      end
      SIZE_HALF: begin
        if (!data_misaligned_ex_i) begin
          // offset 3 keeps only the top lane here
          be_o = be_t'(be_t'(2'b11) << ofs);
        end else begin
          be_o = be_t'(1);
        end
      end
      default: begin
        // a byte never splits
        be_o = be_t'(be_t'(1) << ofs);
      end
    endcase
  end

  //////////////////////////////
  // store data
  //////////////////////////////

  // move the register byte at reg offset onto the lane at the address offset
  assign wdata_ofs = ofs - data_reg_offset_ex_i;
  // rotate left in whole bytes, upper half of the doubled word
  assign wdata_dbl = {data_wdata_ex_i, data_wdata_ex_i} << {wdata_ofs, 3'b000};
  assign wdata_o   = wdata_dbl[63:32];

  //////////////////////////////
  // misalignment
  //////////////////////////////

  // only a first part can be misaligned
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (data_type_ex_i)
        SIZE_WORD: data_misaligned_o = (ofs != 2'd0);
        // halfword crosses only from the top byte
        SIZE_HALF: data_misaligned_o = (ofs == 2'd3);
        default:   data_misaligned_o = 1'b0;
      endcase
    end
  end

endmodule

/* logic/lsu_top.sv */
/*
  load-store unit top level
  connects request former, bus controller and load aligner
*/
`timescale 1ns/100ps

module lsu_top
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // execute stage request
  input  logic      data_req_ex_i,
  input  logic      data_we_ex_i,
  input  size_e     data_type_ex_i,
  input  ext_e      data_sign_ext_ex_i,
  input  data_t     data_wdata_ex_i,
  input  byte_ofs_t data_reg_offset_ex_i,
  input  data_t     operand_a_ex_i,
  input  data_t     operand_b_ex_i,
  input  logic      addr_useincr_ex_i,
  input  logic      data_misaligned_ex_i,
  // execute and writeback stage results
  output data_t     data_rdata_ex_o,
  output logic      data_misaligned_o,
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      busy_o,
  // data bus
  output logic      data_req_o,
  output addr_t     data_addr_o,
  output logic      data_we_o,
  output be_t       data_be_o,
  output data_t     data_wdata_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  data_t     data_rdata_i
);

  // low address bits of the current access
  byte_ofs_t word_offset;
  // execute request moves on to writeback
  logic      ctrl_update;
  logic      resp_valid;

  // direction goes straight to the bus
  assign data_we_o = data_we_ex_i;

  lsu_request_former u_request_former (
    .data_req_ex_i       (data_req_ex_i),
    .data_type_ex_i      (data_type_ex_i),
    .data_wdata_ex_i     (data_wdata_ex_i),
    .data_reg_offset_ex_i(data_reg_offset_ex_i),
    .operand_a_ex_i      (operand_a_ex_i),
    .operand_b_ex_i      (operand_b_ex_i),
    .addr_useincr_ex_i   (addr_useincr_ex_i),
    .data_misaligned_ex_i(data_misaligned_ex_i),
    .addr_o              (data_addr_o),
    .offset_o            (word_offset),
    .be_o                (data_be_o),
    .wdata_o             (data_wdata_o),
    .data_misaligned_o   (data_misaligned_o)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_ex_i (data_req_ex_i),
    .data_we_ex_i  (data_we_ex_i),
    .addr_i        (data_addr_o),
    .be_i          (data_be_o),
    .wdata_i       (data_wdata_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .lsu_ready_ex_o(lsu_ready_ex_o),
    .lsu_ready_wb_o(lsu_ready_wb_o),
    .busy_o        (busy_o),
    .ctrl_update_o (ctrl_update),
    .resp_valid_o  (resp_valid)
  );

  lsu_load_aligner u_load_aligner (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_update_i       (ctrl_update),
    .resp_valid_i        (resp_valid),
    .data_rdata_i        (data_rdata_i),
    .data_type_ex_i      (data_type_ex_i),
    .data_sign_ext_ex_i  (data_sign_ext_ex_i),
    .data_we_ex_i        (data_we_ex_i),
    .offset_i            (word_offset),
    .data_misaligned_ex_i(data_misaligned_ex_i),
    .data_misaligned_i   (data_misaligned_o),
    .data_rdata_ex_o     (data_rdata_ex_o)
  );

endmodule

/* verification/lsu_tb_ref.svh */
/*
  reference model of the load-store unit testbench
  byte enables, store rotation, byte-wise memory merge, load values, compare tasks
*/
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

// bytes touched by one access
function automatic int unsigned access_bytes(size_e size);
  case (size)
    SIZE_WORD: return 4;
    SIZE_HALF: return 2;
    default:   return 1;
  endcase
endfunction

// an access is split when its last byte lies in the next word
function automatic logic ref_misaligned(size_e size, byte_ofs_t ofs);
  return (int'(ofs) + access_bytes(size)) > 4;
endfunction

// lanes of the bytes that fall into this part's word
function automatic be_t ref_be(size_e size, byte_ofs_t ofs, logic second);
  be_t         be;
  int unsigned k;
  int unsigned lane;
  be = '0;
  for (k = 0; k < access_bytes(size); k++) begin
    lane = int'(ofs) + k;
    if (!second && lane < 4) begin
      be[lane] = 1'b1;
    end
    if (second && lane >= 4) begin
      be[lane - 4] = 1'b1;
    end
  end
  return be;
endfunction

// lane j carries register byte j minus offset, register offset 0
function automatic data_t ref_wdata(data_t wdata, byte_ofs_t ofs);
  data_t       w;
  int unsigned j;
  for (j = 0; j < 4; j++) begin
    w[8*j +: 8] = wdata[8*((j + 4 - int'(ofs)) % 4) +: 8];
  end
  return w;
endfunction

// little-endian store into the byte image
task automatic ref_store(addr_t addr, size_e size, data_t wdata);
  int unsigned k;
  for (k = 0; k < access_bytes(size); k++) begin
    ref_bytes[(addr + k) % (MEM_WORDS * 4)] = wdata[8*k +: 8];
  end
endtask

function automatic data_t ref_word(logic [5:0] idx);
  data_t       w;
  int unsigned k;
  for (k = 0; k < 4; k++) begin
    w[8*k +: 8] = ref_bytes[4 * int'(idx) + k];
  end
  return w;
endfunction

// bytes from the address upward, then fill per extension mode
function automatic data_t ref_load(addr_t addr, size_e size, ext_e ext);
  rword_u      w;
  logic        fill;
  int unsigned k;
  for (k = 0; k < 4; k++) begin
    w.b[k] = ref_bytes[(addr + k) % (MEM_WORDS * 4)];
  end
  case (size)
    SIZE_WORD: return data_t'(w);
    SIZE_HALF: begin
      // sign codes have bit 0 set
      fill = (ext == EXT_ONES) || (ext[0] && w.h[0][15]);
      return {{16{fill}}, w.h[0]};
    end
    default: begin
      fill = (ext == EXT_ONES) || (ext[0] && w.b[0][7]);
      return {{24{fill}}, w.b[0]};
    end
  endcase
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_data(string what, data_t got, data_t exp_val);
  if (got !== exp_val) begin
    $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp_val);
    err_count++;
  end
endtask

task automatic check_addr(string what, addr_t got, addr_t exp_val);
  if (got !== exp_val) begin
    $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp_val);
    err_count++;
  end
endtask

task automatic check_be(string what, be_t got, be_t exp_val);
  if (got !== exp_val) begin
    $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp_val);
    err_count++;
  end
endtask

task automatic check_flag(string what, logic got, logic exp_val);
  if (got !== exp_val) begin
    $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp_val);
    err_count++;
  end
endtask

`endif

/* verification/lsu_tb.sv */
/*
  testbench for the load-store unit
  random execute-stage accesses against a req/gnt/rvalid memory model
*/
`timescale 1ns/100ps

module lsu_tb
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
();

  localparam int unsigned N_ACCESS    = 300;
  localparam int unsigned TIMEOUT_CYC = 50;
  localparam int unsigned MEM_WORDS   = 64;

  logic      clk;
  logic      rst_n;
  // execute stage side
  logic      data_req_ex;
  logic      data_we_ex;
  size_e     data_type_ex;
  ext_e      data_sign_ext_ex;
  data_t     data_wdata_ex;
  byte_ofs_t data_reg_offset_ex;
  data_t     operand_a_ex;
  data_t     operand_b_ex;
  logic      addr_useincr_ex;
  logic      data_misaligned_ex;
  data_t     data_rdata_ex;
  logic      data_misaligned;
  logic      lsu_ready_ex;
  logic      lsu_ready_wb;
  logic      busy;
  // bus side
  logic      data_req;
  addr_t     data_addr;
  logic      data_we;
  be_t       data_be;
  data_t     data_wdata;
  logic      data_gnt;
  logic      data_rvalid;
  data_t     data_rdata;

  // bus memory and its byte-wise reference image
  data_t       mem [MEM_WORDS];
  logic [7:0]  ref_bytes [MEM_WORDS*4];
  // expectations per bus transfer, in issue order
  addr_t       exp_addr_q [$];
  be_t         exp_be_q [$];
  data_t       exp_wdata_q [$];
  logic        exp_we_q [$];
  logic        exp_chk_q [$];
  // transfer is a read and its response reaches the load buffer
  logic        exp_rd_q [$];
  data_t       exp_load_q [$];
  int unsigned err_count;
  int unsigned fail_count;
  int unsigned n_accept;
  int unsigned n_rvalid;

  `include "lsu_tb_ref.svh"

  lsu_top i_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .data_req_ex_i       (data_req_ex),
    .data_we_ex_i        (data_we_ex),
    .data_type_ex_i      (data_type_ex),
    .data_sign_ext_ex_i  (data_sign_ext_ex),
    .data_wdata_ex_i     (data_wdata_ex),
    .data_reg_offset_ex_i(data_reg_offset_ex),
    .operand_a_ex_i      (operand_a_ex),
    .operand_b_ex_i      (operand_b_ex),
    .addr_useincr_ex_i   (addr_useincr_ex),
    .data_misaligned_ex_i(data_misaligned_ex),
    .data_rdata_ex_o     (data_rdata_ex),
    .data_misaligned_o   (data_misaligned),
    .lsu_ready_ex_o      (lsu_ready_ex),
    .lsu_ready_wb_o      (lsu_ready_wb),
    .busy_o              (busy),
    .data_req_o          (data_req),
    .data_addr_o         (data_addr),
    .data_we_o           (data_we),
    .data_be_o           (data_be),
    .data_wdata_o        (data_wdata),
    .data_gnt_i          (data_gnt),
    .data_rvalid_i       (data_rvalid),
    .data_rdata_i        (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // bus memory model
  //////////////////////////////

  // samples at negedge, drives 2 ns after posedge
  initial begin : bus_model
    int unsigned cyc;
    int unsigned gnt_wait;
    int unsigned last_due;
    int unsigned due;
    int unsigned k;
    int unsigned due_q [$];
    data_t       rdata_q [$];
    logic [5:0]  widx;
    cyc         = 0;
    gnt_wait    = 0;
    last_due    = 0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    forever begin
      @(negedge clk);
      cyc++;
      widx = data_addr[7:2];
      if (data_rvalid) begin
        void'(due_q.pop_front());
        void'(rdata_q.pop_front());
      end
      if (data_req && data_gnt) begin
        if (data_we) begin
          for (k = 0; k < 4; k++) begin
            if (data_be[k]) begin
              mem[widx][8*k +: 8] = data_wdata[8*k +: 8];
            end
          end
        end
        // 1 or 2 cycles later, never two responses in one cycle
        due = cyc + 1 + ($urandom % 2);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        rdata_q.push_back(data_we ? data_t'($urandom) : mem[widx]);
        gnt_wait = $urandom % 3;
      end else if (data_req && gnt_wait != 0) begin
        gnt_wait--;
      end
      @(posedge clk);
      #2;
      data_gnt = (gnt_wait == 0);
      if (due_q.size() != 0 && due_q[0] == cyc + 1) begin
        data_rvalid = 1'b1;
        data_rdata  = rdata_q[0];
      end else begin
        data_rvalid = 1'b0;
        data_rdata  = data_t'($urandom);
      end
    end
  end

  //////////////////////////////
  // compare process
  //////////////////////////////

  always @(negedge clk) begin : compare
    logic  held_valid;
    addr_t held_addr;
    be_t   held_be;
    logic  held_we;
    data_t held_wdata;
    logic  chk;
    logic  rd;
    logic  load_valid;
    data_t load_val;
    data_t exp_val;
    if (!rst_n) begin
      held_valid = 1'b0;
      load_valid = 1'b0;
    end else begin
      // a waiting request keeps its address phase
      if (held_valid) begin
        check_flag("data_req_o while waiting for grant", data_req, 1'b1);
        check_addr("held bus address", data_addr, held_addr);
        check_be("held byte enables", data_be, held_be);
        check_flag("held write enable", data_we, held_we);
        check_data("held write data", data_wdata, held_wdata);
      end
      if (data_req && data_gnt) begin
        if (exp_addr_q.size() == 0) begin
          $display("a bus transfer was accepted with no access pending");
          fail_count++;
        end else begin
          check_addr("bus address", data_addr, exp_addr_q.pop_front());
          check_be("byte enables", data_be, exp_be_q.pop_front());
          check_flag("write enable", data_we, exp_we_q.pop_front());
          exp_val = exp_wdata_q.pop_front();
          if (data_we) begin
            check_data("bus write data", data_wdata, exp_val);
          end
        end
        n_accept++;
      end
      if (data_rvalid) begin
        if (exp_chk_q.size() == 0) begin
          $display("a response arrived with no transfer pending");
          fail_count++;
        end else begin
          chk     = exp_chk_q.pop_front();
          rd      = exp_rd_q.pop_front();
          exp_val = exp_load_q.pop_front();
          // only the last part of a load carries the result
          if (chk) begin
            check_data("load data", data_rdata_ex, exp_val);
            load_valid = 1'b1;
            load_val   = exp_val;
          end else if (rd) begin
            // first part of a split load leaves no result behind
            load_valid = 1'b0;
          end
        end
        n_rvalid++;
      end else if (load_valid) begin
        // last load result stays on the output between responses
        check_data("held load data", data_rdata_ex, load_val);
      end
      if (n_accept - n_rvalid > int'(OUTSTANDING_MAX)) begin
        $display("more than two bus transfers are outstanding");
        fail_count++;
      end
      held_valid = data_req && !data_gnt;
      held_addr  = data_addr;
      held_be    = data_be;
      held_we    = data_we;
      held_wdata = data_wdata;
    end
  end

  //////////////////////////////
  // execute stage driver
  //////////////////////////////

  // one bus part, held until the unit takes it
  task automatic issue_part(addr_t eff, data_t op_a, logic second, logic exp_mis,
                            data_t exp_val);
    int unsigned cycles;
    logic        done;
    operand_a_ex       = op_a;
    data_misaligned_ex = second;
    data_req_ex        = 1'b1;
    exp_addr_q.push_back(second ? {eff[31:2], 2'b00} : eff);
    exp_be_q.push_back(ref_be(data_type_ex, eff[1:0], second));
    exp_wdata_q.push_back(ref_wdata(data_wdata_ex, eff[1:0]));
    exp_we_q.push_back(data_we_ex);
    // first part of a split access is not final
    exp_chk_q.push_back(!data_we_ex && !exp_mis);
    exp_rd_q.push_back(!data_we_ex);
    exp_load_q.push_back(exp_val);
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT_CYC) begin
      @(negedge clk);
      if (cycles == 0) begin
        check_flag("data_misaligned_o", data_misaligned, exp_mis);
      end
      done = lsu_ready_ex;
      cycles++;
    end
    if (!done) begin
      $display("lsu_ready_ex_o stayed low for %0d cycles", TIMEOUT_CYC);
      fail_count++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic run_access(addr_t addr, data_t op_b, logic useincr, logic we,
                            size_e size, ext_e ext, data_t wdata);
    logic       split;
    data_t      op_a;
    data_t      exp_val;
    logic [5:0] widx;
    split = ref_misaligned(size, addr[1:0]);
    // base register so that the sum lands on addr
    op_a  = useincr ? data_t'(addr - op_b) : data_t'(addr);
    exp_val            = ref_load(addr, size, ext);
    data_we_ex         = we;
    data_type_ex       = size;
    data_sign_ext_ex   = ext;
    data_wdata_ex      = wdata;
    data_reg_offset_ex = '0;
    addr_useincr_ex    = useincr;
    // an unused operand b carries noise
    operand_b_ex       = useincr ? op_b : data_t'($urandom);
    issue_part(addr, op_a, 1'b0, split, exp_val);
    if (split && fail_count == 0) begin
      issue_part(addr + 4, op_a + 4, 1'b1, 1'b0, exp_val);
    end
    if (we && fail_count == 0) begin
      ref_store(addr, size, wdata);
      widx = addr[7:2];
      check_data("memory word", mem[widx], ref_word(widx));
      if (split) begin
        check_data("next memory word", mem[widx + 1], ref_word(widx + 1));
      end
    end
  endtask

  initial begin : driver
    int unsigned n;
    int unsigned i;
    int unsigned k;
    int unsigned cycles;
    void'($urandom(46));
    err_count          = 0;
    fail_count         = 0;
    n_accept           = 0;
    n_rvalid           = 0;
    rst_n              = 1'b0;
    data_req_ex        = 1'b0;
    data_we_ex         = 1'b0;
    data_type_ex       = SIZE_WORD;
    data_sign_ext_ex   = EXT_ZERO;
    data_wdata_ex      = '0;
    data_reg_offset_ex = '0;
    operand_a_ex       = '0;
    operand_b_ex       = '0;
    addr_useincr_ex    = 1'b0;
    data_misaligned_ex = 1'b0;
    // fill pattern spread over every address bit
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i] = data_t'(i + 1) * 32'h9E37_79B9;
      for (k = 0; k < 4; k++) begin
        ref_bytes[4*i + k] = mem[i][8*k +: 8];
      end
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("data_req_o after reset", data_req, 1'b0);
    check_flag("busy_o after reset", busy, 1'b0);
    check_flag("lsu_ready_ex_o after reset", lsu_ready_ex, 1'b1);
    check_flag("lsu_ready_wb_o after reset", lsu_ready_wb, 1'b1);
    @(posedge clk);
    #2;
    for (n = 0; n < N_ACCESS && fail_count == 0; n++) begin
      // addresses stay below the top of the 256-byte image
      run_access(addr_t'($urandom % 240), data_t'($urandom % 64), 1'($urandom),
                 1'($urandom), size_e'($urandom % 4), ext_e'($urandom % 4),
                 data_t'($urandom));
      if ($urandom % 4 == 0) begin
        // idle execute stage carries no second part
        data_req_ex        = 1'b0;
        data_misaligned_ex = 1'b0;
        @(posedge clk);
        #2;
      end
    end
    data_req_ex        = 1'b0;
    data_misaligned_ex = 1'b0;
    // let the last responses come back
    cycles = 0;
    while (n_accept != n_rvalid && cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    if (n_accept != n_rvalid) begin
      $display("outstanding bus responses never arrived");
      fail_count++;
    end
    @(negedge clk);
    check_flag("busy_o when idle", busy, 1'b0);
    check_flag("lsu_ready_wb_o when idle", lsu_ready_wb, 1'b1);
    $display("accesses %0d, transfers %0d, value errors %0d, other failures %0d",
             n, n_accept, err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
